/* logic/video_pkg.sv */
package video_pkg;

    ////////////////////
    // raster geometry
    ////////////////////
    localparam int H_NUM    = 1920;         // left + middle panes together
    localparam int H_HALF   = H_NUM / 2;    // first x of the middle pane
    localparam int X_WIDTH  = 13;           // pixel / line counter width
    localparam int PANE_CNT = 3;            // left, middle, right

    ////////////////////
    // word and pixel packing
    ////////////////////
    localparam int WORD_WIDTH = 32;         // line-buffer word
    localparam int PIX_WIDTH  = 24;         // rgb888

    typedef logic [X_WIDTH-1:0]    coord_t;     // pixel or line index
    typedef logic [WORD_WIDTH-1:0] word_t;
    typedef logic [PIX_WIDTH-1:0]  pixel_t;
    typedef logic [1:0]            phase_t;     // 3 words carry 4 pixels

    // last pixel of a group lives entirely in the word already held
    localparam phase_t PHASE_SKIP = 2'd3;   // no fetch at this phase

    // pane index, also the bit position in pane_en
    typedef enum logic [1:0]
    {
        PANE_LEFT  = 2'd0,                  // x < H_HALF
        PANE_MID   = 2'd1,                  // H_HALF <= x < H_NUM
        PANE_RIGHT = 2'd2                   // x >= H_NUM
    } pane_e;

endpackage

/* logic/osd_pkg.sv */
package osd_pkg;

    ////////////////////
    // digit box placement
    ////////////////////
    localparam int OSD_X   = 8;             // left column of the box
    localparam int OSD_Y   = 2;             // top line of the box
    localparam int OSD_W   = 16;            // box width
    localparam int OSD_H   = 32;            // box height
    localparam int SEG_T   = 2;             // bar thickness
    localparam int SEG_MID = OSD_H / 2;     // g bar straddles this row
    localparam int SEG_CNT = 7;             // a..g

    localparam logic [23:0] OSD_COLOR = 24'h00F800;   // lit segment colour

    typedef logic [3:0] digit_t;
    localparam digit_t DIGIT_BLANK = 4'd10;           // any code above 9 draws nothing

    // bit positions of the segment vector
    typedef enum logic [2:0]
    {
        SEG_A, SEG_B, SEG_C, SEG_D, SEG_E, SEG_F, SEG_G
    } seg_e;

endpackage

/* logic/pane_if.sv */
interface pane_if;

    video_pkg::word_t  word;        // word for the pixel in flight
    video_pkg::word_t  prev_word;   // word before it in the byte stream
    video_pkg::phase_t phase;       // pixel slot within its group of 4
    logic              active;      // this pane owns the pixel in flight

    modport fetch
    (
        output word,
        output prev_word,
        output phase,
        output active
    );

    modport unpack
    (
        input  word,
        input  prev_word,
        input  phase,
        input  active
    );

endinterface

/* logic/raster_counter.sv */
module raster_counter
(
    input  logic                            vout_clk,
    input  logic                            arst_n,
    input  logic                            rd_fsync,
    input  logic                            rd_en,
    output video_pkg::coord_t               x,
    output video_pkg::coord_t               y,
    output logic                            de_1d,
    output logic                            de_2d,
    output logic [video_pkg::PANE_CNT-1:0]  pane_en
);

    logic fsync_1d;     // previous frame sync level
    logic fsync_rise;   // new frame
    logic line_end;     // first cycle after a line

    assign fsync_rise = rd_fsync & ~fsync_1d;
    assign line_end   = de_1d & ~rd_en;

    always_ff @(posedge vout_clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            x        <= '0;
            y        <= '0;
            de_1d    <= 1'b0;
            de_2d    <= 1'b0;
            fsync_1d <= 1'b0;
        end
        else
        begin
            if (rd_en)
                x <= x + 1'b1;          // x is 0 in the first rd_en cycle
            else
                x <= '0;
            if (fsync_rise)
                y <= '0;                // line 0 of the new frame
            else if (line_end)
                y <= y + 1'b1;
            de_1d    <= rd_en;
            de_2d    <= de_1d;          // aligned with vout_data
            fsync_1d <= rd_fsync;
        end
    end

    // pane ownership of the current x, only while reading
    always_comb
    begin
        pane_en = '0;
        if (x < video_pkg::coord_t'(video_pkg::H_HALF))
            pane_en[video_pkg::PANE_LEFT] = rd_en;
        else if (x < video_pkg::coord_t'(video_pkg::H_NUM))
            pane_en[video_pkg::PANE_MID] = rd_en;
        else
            pane_en[video_pkg::PANE_RIGHT] = rd_en;
    end

endmodule

/* logic/pane_fetch.sv */
module pane_fetch
(
    input  logic             vout_clk,
    input  logic             arst_n,
    input  logic             en,        // pane owns this pixel, rd_en included
    input  logic             rd_en,
    input  video_pkg::word_t word_in,   // buffer answer, one cycle after rd
    output logic             rd,
    pane_if.fetch            pif
);

    video_pkg::phase_t phase_q;     // pixel count in the pane, mod 4
    video_pkg::phase_t phase_1d;
    logic              rd_1d;       // word_in valid this cycle
    logic              en_1d;
    video_pkg::word_t  word_q;      // newest word taken
    video_pkg::word_t  prev_q;      // the one before

    assign rd = en & (phase_q != video_pkg::PHASE_SKIP);

    ////////////////////
    // phase and strobe delay
    ////////////////////
    always_ff @(posedge vout_clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            phase_q  <= '0;
            phase_1d <= '0;
            rd_1d    <= 1'b0;
            en_1d    <= 1'b0;
        end
        else
        begin
            if (!rd_en)
                phase_q <= '0;                  // restart every line
            else if (en)
                phase_q <= phase_q + 1'b1;      // wraps 3 -> 0
            phase_1d <= phase_q;
            rd_1d    <= rd;
            en_1d    <= en;
        end
    end

    // word history, shifted on each arrival
    always_ff @(posedge vout_clk)
    begin
        if (rd_1d)
        begin
            word_q <= word_in;
            prev_q <= word_q;
        end
    end

    // arriving word bypasses the register so the unpacker sees it in time
    assign pif.word      = rd_1d ? word_in : word_q;
    assign pif.prev_word = rd_1d ? word_q  : prev_q;
    assign pif.phase     = phase_1d;
    assign pif.active    = en_1d;

endmodule

/* logic/pixel_unpack.sv */
module pixel_unpack
(
    input  logic              vout_clk,
    input  logic              arst_n,
    input  video_pkg::coord_t x,
    input  logic              de_1d,
    pane_if.unpack            pif0,     // left
    pane_if.unpack            pif1,     // middle
    pane_if.unpack            pif2,     // right
    output video_pkg::pixel_t pixel
);

    video_pkg::pane_e  sel;         // pane of the pixel in flight
    video_pkg::word_t  cur;
    video_pkg::word_t  prv;
    video_pkg::phase_t ph;
    logic              pix_vld;

    // x has already stepped past the pixel in flight, 0 means none
    assign pix_vld = de_1d & (x != '0);

    // registered ownership from the fetch stage
    always_comb
    begin
        if (pif0.active)
            sel = video_pkg::PANE_LEFT;
        else if (pif1.active)
            sel = video_pkg::PANE_MID;
        else if (pif2.active)
            sel = video_pkg::PANE_RIGHT;
        else
            sel = video_pkg::PANE_LEFT;     // idle, output forced to 0 anyway
    end

    always_comb
    begin
        case (sel)
            video_pkg::PANE_MID:
            begin
                cur = pif1.word;
                prv = pif1.prev_word;
                ph  = pif1.phase;
            end
            video_pkg::PANE_RIGHT:
            begin
                cur = pif2.word;
                prv = pif2.prev_word;
                ph  = pif2.phase;
            end
            default:
            begin
                cur = pif0.word;
                prv = pif0.prev_word;
                ph  = pif0.phase;
            end
        endcase
    end

    ////////////////////
    // byte stream to rgb888, lowest byte first
    ////////////////////
    always_ff @(posedge vout_clk or negedge arst_n)
    begin
        if (!arst_n)
            pixel <= '0;
        else if (!pix_vld)
            pixel <= '0;                                // blank outside a line
        else
        begin
            case (ph)
                2'd0:    pixel <= cur[23:0];            // bytes 0..2
                2'd1:    pixel <= {cur[15:0], prv[31:24]};
                2'd2:    pixel <= {cur[7:0], prv[31:16]};
                default: pixel <= cur[31:8];            // no fetch, same word
            endcase
        end
    end

endmodule

/* logic/osd_digit_reg.sv */
module osd_digit_reg
(
    input  logic            vout_clk,
    input  logic            arst_n,
    input  logic [3:0]      num,
    input  logic            num_vld,
    output osd_pkg::digit_t digit
);

    osd_pkg::digit_t num_1d;    // two-flop sync of the value
    osd_pkg::digit_t num_2d;
    logic            vld_1d;
    logic            vld_2d;    // synchronised valid
    logic            vld_3d;    // edge detect
    logic            num_en;    // sticky, set by the first valid

    always_ff @(posedge vout_clk)
    begin
        num_1d <= num;
        num_2d <= num_1d;
    end

    always_ff @(posedge vout_clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            vld_1d <= 1'b0;
            vld_2d <= 1'b0;
            vld_3d <= 1'b0;
            num_en <= 1'b0;
            digit  <= osd_pkg::DIGIT_BLANK;
        end
        else
        begin
            vld_1d <= num_vld;
            vld_2d <= vld_1d;
            vld_3d <= vld_2d;
            if (vld_2d & ~vld_3d)
                num_en <= 1'b1;                 // never cleared
            digit <= num_en ? num_2d : osd_pkg::DIGIT_BLANK;   // tracks num afterwards
        end
    end

endmodule

/* logic/osd_overlay.sv */
module osd_overlay
(
    input  logic              vout_clk,
    input  logic              arst_n,
    input  video_pkg::coord_t x,
    input  video_pkg::coord_t y,
    input  osd_pkg::digit_t   digit,
    input  video_pkg::pixel_t pixel,
    input  logic              de_2d,
    output video_pkg::pixel_t vout_data
);

    int                          col;       // box-relative column
    int                          row;       // box-relative row
    logic                        in_box;
    logic                        row_top, row_mid, row_bot, row_up, row_lo;
    logic                        col_h, col_l, col_r;
    logic [osd_pkg::SEG_CNT-1:0] seg_hit;   // segments covering (col, row)
    logic [osd_pkg::SEG_CNT-1:0] seg_lit;   // segments the digit turns on
    logic                        hit;
    logic                        hit_1d;
    logic                        hit_2d;    // same stage as pixel

    function automatic logic in_rng(input int v, input int lo, input int hi);
        return (v >= lo) && (v <= hi);
    endfunction

    // bit order g..a, indexed by seg_e
    function automatic logic [osd_pkg::SEG_CNT-1:0] seg_map(input osd_pkg::digit_t d);
        case (d)
            4'd0:    return 7'b0111111;
            4'd1:    return 7'b0000110;
            4'd2:    return 7'b1011011;
            4'd3:    return 7'b1001111;
            4'd4:    return 7'b1100110;
            4'd5:    return 7'b1101101;
            4'd6:    return 7'b1111101;
            4'd7:    return 7'b0000111;
            4'd8:    return 7'b1111111;
            4'd9:    return 7'b1101111;
            default: return '0;             // 10..15 blank
        endcase
    endfunction

    ////////////////////
    // segment hit test
    ////////////////////
    always_comb
    begin
        col     = int'(x) - osd_pkg::OSD_X;
        row     = int'(y) - osd_pkg::OSD_Y;
        in_box  = in_rng(col, 0, osd_pkg::OSD_W - 1) && in_rng(row, 0, osd_pkg::OSD_H - 1);
        row_top = in_rng(row, 0, osd_pkg::SEG_T - 1);
        row_mid = in_rng(row, osd_pkg::SEG_MID - osd_pkg::SEG_T / 2,
                         osd_pkg::SEG_MID + osd_pkg::SEG_T / 2 - 1);
        row_bot = in_rng(row, osd_pkg::OSD_H - osd_pkg::SEG_T, osd_pkg::OSD_H - 1);
        row_up  = in_rng(row, osd_pkg::SEG_T, osd_pkg::SEG_MID - osd_pkg::SEG_T / 2 - 1);
        row_lo  = in_rng(row, osd_pkg::SEG_MID + osd_pkg::SEG_T / 2,
                         osd_pkg::OSD_H - osd_pkg::SEG_T - 1);
        col_h   = in_rng(col, osd_pkg::SEG_T, osd_pkg::OSD_W - osd_pkg::SEG_T - 1);
        col_l   = in_rng(col, 0, osd_pkg::SEG_T - 1);
        col_r   = in_rng(col, osd_pkg::OSD_W - osd_pkg::SEG_T, osd_pkg::OSD_W - 1);
    end

    always_comb
    begin
        seg_hit                = '0;
        seg_hit[osd_pkg::SEG_A] = row_top & col_h;
        seg_hit[osd_pkg::SEG_B] = row_up  & col_r;
        seg_hit[osd_pkg::SEG_C] = row_lo  & col_r;
        seg_hit[osd_pkg::SEG_D] = row_bot & col_h;
        seg_hit[osd_pkg::SEG_E] = row_lo  & col_l;
        seg_hit[osd_pkg::SEG_F] = row_up  & col_l;
        seg_hit[osd_pkg::SEG_G] = row_mid & col_h;
    end

    assign seg_lit = seg_map(digit);
    assign hit     = in_box & |(seg_hit & seg_lit);

    // two stages, matching fetch + unpack
    always_ff @(posedge vout_clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            hit_1d <= 1'b0;
            hit_2d <= 1'b0;
        end
        else
        begin
            hit_1d <= hit;
            hit_2d <= hit_1d;
        end
    end

    assign vout_data = (de_2d & hit_2d) ? osd_pkg::OSD_COLOR : pixel;   // pixel is 0 off-line

endmodule

/* logic/vout_reader_top.sv */
module vout_reader_top
(
    input  logic              vout_clk,
    input  logic              arst_n,
    input  logic              rd_fsync,
    input  logic              rd_en,
    input  video_pkg::word_t  pane_word [video_pkg::PANE_CNT],
    input  logic [3:0]        num,
    input  logic              num_vld,
    output logic              pane_rd [video_pkg::PANE_CNT],
    output logic              vout_de,
    output video_pkg::pixel_t vout_data
);

    video_pkg::coord_t                x;
    video_pkg::coord_t                y;
    logic                             de_1d;
    logic                             de_2d;
    logic [video_pkg::PANE_CNT-1:0]   pane_en;
    osd_pkg::digit_t                  digit;
    video_pkg::pixel_t                pixel;

    pane_if pif [video_pkg::PANE_CNT] ();   // one word stream per pane

    raster_counter u_raster
    (
        .vout_clk (vout_clk),
        .arst_n   (arst_n),
        .rd_fsync (rd_fsync),
        .rd_en    (rd_en),
        .x        (x),
        .y        (y),
        .de_1d    (de_1d),
        .de_2d    (de_2d),
        .pane_en  (pane_en)
    );

    for (genvar i = 0; i < video_pkg::PANE_CNT; i++)
    begin : g_pane
        pane_fetch u_fetch
        (
            .vout_clk (vout_clk),
            .arst_n   (arst_n),
            .en       (pane_en[i]),
            .rd_en    (rd_en),
            .word_in  (pane_word[i]),
            .rd       (pane_rd[i]),
            .pif      (pif[i])
        );
    end

    pixel_unpack u_unpack
    (
        .vout_clk (vout_clk),
        .arst_n   (arst_n),
        .x        (x),
        .de_1d    (de_1d),
        .pif0     (pif[0]),
        .pif1     (pif[1]),
        .pif2     (pif[2]),
        .pixel    (pixel)
    );

    osd_digit_reg u_digit
    (
        .vout_clk (vout_clk),
        .arst_n   (arst_n),
        .num      (num),
        .num_vld  (num_vld),
        .digit    (digit)
    );

    osd_overlay u_osd
    (
        .vout_clk  (vout_clk),
        .arst_n    (arst_n),
        .x         (x),
        .y         (y),
        .digit     (digit),
        .pixel     (pixel),
        .de_2d     (de_2d),
        .vout_data (vout_data)
    );

    assign vout_de = de_2d;     // rd_en two cycles late

endmodule

/* verification/vout_reader_checker.sv */
module vout_reader_checker
(
    input logic              vout_clk,
    input logic              arst_n,
    input logic              rd_en,
    input logic              pane_rd [video_pkg::PANE_CNT],
    input logic              vout_de,
    input video_pkg::pixel_t vout_data
);

    timeunit 1ns;
    timeprecision 100ps;

    ////////////////////
    // output timing
    ////////////////////
    de_delay: assert property (@(posedge vout_clk) disable iff (!arst_n)
        vout_de == $past(rd_en, 2))                         // two register stages
        else $error("vout_de is not rd_en delayed by two cycles");

    data_blank: assert property (@(posedge vout_clk) disable iff (!arst_n)
        !vout_de |-> vout_data == '0)                       // blank between lines
        else $error("vout_data is not zero while vout_de is low");

    ////////////////////
    // buffer strobes
    ////////////////////
    rd_onehot: assert property (@(posedge vout_clk) disable iff (!arst_n)
        $onehot0({pane_rd[0], pane_rd[1], pane_rd[2]}))     // one pane owns each x
        else $error("more than one pane_rd is high in the same cycle");

endmodule

bind vout_reader_top vout_reader_checker u_checker
(
    .vout_clk  (vout_clk),
    .arst_n    (arst_n),
    .rd_en     (rd_en),
    .pane_rd   (pane_rd),
    .vout_de   (vout_de),
    .vout_data (vout_data)
);

/* verification/vout_reader_tb.sv */
module vout_reader_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int     LINE_LEN        = 2400;                  // spans all three panes
    localparam int     LINES_PER_FRAME = 36;                    // box ends on line 33
    localparam int     N_FRAMES        = 11;                    // blank frame then digits 0..9
    localparam int     N_LINES         = LINES_PER_FRAME * N_FRAMES;
    localparam longint WATCHDOG_NS     = longint'(N_LINES) * 2600 * 8;
    localparam int     TAB_WORDS       = 720;                   // 960 px of a full pane

    logic              vout_clk;
    logic              arst_n    = 1'b0;
    logic              rd_fsync  = 1'b0;
    logic              rd_en     = 1'b0;
    video_pkg::word_t  pane_word [video_pkg::PANE_CNT] = '{default: '0};
    logic [3:0]        num       = 4'd0;
    logic              num_vld   = 1'b0;
    logic              pane_rd [video_pkg::PANE_CNT];
    logic              vout_de;
    video_pkg::pixel_t vout_data;

    logic              exp_de    = 1'b0;        // expectation for this rd_en cycle
    video_pkg::pixel_t exp_data  = '0;
    logic              de_p1     = 1'b0;        // expectation pipe
    logic              de_p2     = 1'b0;
    video_pkg::pixel_t data_p1   = '0;
    video_pkg::pixel_t data_p2   = '0;

    video_pkg::word_t  word_tab [video_pkg::PANE_CNT][TAB_WORDS];  // random word contents
    int                word_idx     [video_pkg::PANE_CNT] = '{default: 0};
    int                strobes_seen [video_pkg::PANE_CNT] = '{default: 0};
    int                strobes_exp  [video_pkg::PANE_CNT] = '{default: 0};
    int                line_seq  = 0;           // lines driven so far
    int                line_y    = 0;           // line within the frame
    int                exp_digit = int'(osd_pkg::DIGIT_BLANK);
    int                fail_cnt  = 0;

    vout_reader_top dut0
    (
        .vout_clk  (vout_clk),
        .arst_n    (arst_n),
        .rd_fsync  (rd_fsync),
        .rd_en     (rd_en),
        .pane_word (pane_word),
        .num       (num),
        .num_vld   (num_vld),
        .pane_rd   (pane_rd),
        .vout_de   (vout_de),
        .vout_data (vout_data)
    );

    initial
    begin
        vout_clk = 1'b0;
        forever #4 vout_clk = ~vout_clk;        // 8 ns period
    end

    ////////////////////
    // reference model
    ////////////////////
    function automatic bit in_span(input int v, input int lo, input int hi);
        return (v >= lo) && (v <= hi);
    endfunction

    function automatic string digit_segments(input int dg);
        case (dg)
            0:       return "abcdef";
            1:       return "bc";
            2:       return "abdeg";
            3:       return "abcdg";
            4:       return "bcfg";
            5:       return "acdfg";
            6:       return "acdefg";
            7:       return "abc";
            8:       return "abcdefg";
            9:       return "abcdfg";
            default: return "";                 // 10..15 draw nothing
        endcase
    endfunction

    function automatic bit segment_lit(input int px, input int ln, input int dg);
        int    c;
        int    r;
        string segs;
        bit    on;
        c  = px - osd_pkg::OSD_X;               // box-relative column
        r  = ln - osd_pkg::OSD_Y;               // box-relative row
        on = 1'b0;
        if (!in_span(c, 0, osd_pkg::OSD_W - 1) || !in_span(r, 0, osd_pkg::OSD_H - 1))
            return 1'b0;
        segs = digit_segments(dg);
        for (int i = 0; i < segs.len(); i++)
        begin
            case (segs[i])
                "a": on |= in_span(r, 0, 1)   && in_span(c, 2, 13);
                "b": on |= in_span(r, 2, 14)  && in_span(c, 14, 15);
                "c": on |= in_span(r, 17, 29) && in_span(c, 14, 15);
                "d": on |= in_span(r, 30, 31) && in_span(c, 2, 13);
                "e": on |= in_span(r, 17, 29) && in_span(c, 0, 1);
                "f": on |= in_span(r, 2, 14)  && in_span(c, 0, 1);
                "g": on |= in_span(r, 15, 16) && in_span(c, 2, 13);
                default: on |= 1'b0;
            endcase
        end
        return on;
    endfunction

    function automatic video_pkg::word_t line_word(input int pane, input int seq, input int idx);
        return word_tab[pane][idx] ^ (32'(seq) * 32'h9E37_79B1);   // differs per line
    endfunction

    function automatic video_pkg::pixel_t expected_pixel(input int px, input int ln,
                                                         input int seq, input int dg);
        int                pane;
        int                n;
        int                b;
        video_pkg::word_t  w;
        video_pkg::pixel_t pix;
        if (segment_lit(px, ln, dg))
            return osd_pkg::OSD_COLOR;
        if (px < video_pkg::H_HALF)
        begin
            pane = 0;
            n    = px;
        end
        else if (px < video_pkg::H_NUM)
        begin
            pane = 1;
            n    = px - video_pkg::H_HALF;      // stream restarts at the pane edge
        end
        else
        begin
            pane = 2;
            n    = px - video_pkg::H_NUM;
        end
        pix = '0;
        for (int k = 0; k < 3; k++)
        begin
            b = 3 * n + k;                      // byte index in the pane stream
            w = line_word(pane, seq, b / 4);
            pix[8*k +: 8] = w[8*(b % 4) +: 8];  // lowest byte first
        end
        return pix;
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp)
        begin
            fail_cnt++;
            $display("Fail at %0d ns: %s is %0h, expected %0h", $time, what, got, exp);
            $display("TB FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    ////////////////////
    // line buffer models
    ////////////////////
    always @(posedge vout_clk)
    begin
        for (int p = 0; p < video_pkg::PANE_CNT; p++)
        begin
            if (pane_rd[p])
            begin
                pane_word[p]    <= line_word(p, line_seq, word_idx[p]);
                word_idx[p]     <= word_idx[p] + 1;
                strobes_seen[p] <= strobes_seen[p] + 1;
            end
            else if (!rd_en)
                word_idx[p] <= 0;               // rewinds between lines
        end
    end

    // output compare two cycles behind rd_en
    always @(posedge vout_clk)
    begin
        if (arst_n)
        begin
            check_value("vout_de", 32'(vout_de), 32'(de_p2));
            check_value("vout_data", 32'(vout_data), 32'(data_p2));
        end
        de_p1   <= exp_de;
        de_p2   <= de_p1;
        data_p1 <= exp_data;
        data_p2 <= data_p1;
    end

    task automatic run_line(input int gap);
        int n_pix [video_pkg::PANE_CNT];
        n_pix[0] = (LINE_LEN < video_pkg::H_HALF) ? LINE_LEN : video_pkg::H_HALF;
        n_pix[2] = (LINE_LEN > video_pkg::H_NUM) ? LINE_LEN - video_pkg::H_NUM : 0;
        n_pix[1] = LINE_LEN - n_pix[0] - n_pix[2];
        for (int i = 0; i < LINE_LEN; i++)
        begin
            @(posedge vout_clk);
            rd_en    <= 1'b1;
            exp_de   <= 1'b1;
            exp_data <= expected_pixel(i, line_y, line_seq, exp_digit);
        end
        @(posedge vout_clk);
        rd_en    <= 1'b0;
        exp_de   <= 1'b0;
        exp_data <= '0;                         // gap must stay black
        repeat (gap) @(posedge vout_clk);
        for (int p = 0; p < video_pkg::PANE_CNT; p++)
        begin
            strobes_exp[p] += n_pix[p] - n_pix[p] / 4;     // no fetch at phase 3
            check_value("pane_rd strobe count", strobes_seen[p], strobes_exp[p]);
        end
        line_y++;
        line_seq++;
    endtask

    task automatic run_frame(input int dg);
        if (dg >= 0)
        begin
            @(posedge vout_clk);
            num     <= 4'(dg);
            num_vld <= 1'b1;
            @(posedge vout_clk);
            num_vld <= 1'b0;
            repeat (8) @(posedge vout_clk);     // sync and digit register settle
            exp_digit = dg;
        end
        @(posedge vout_clk);
        rd_fsync <= 1'b1;                       // rising edge restarts y
        repeat (2) @(posedge vout_clk);
        rd_fsync <= 1'b0;
        @(posedge vout_clk);
        line_y = 0;
        for (int l = 0; l < LINES_PER_FRAME; l++)
            run_line(1 + int'($urandom % 16));
    endtask

    ////////////////////
    // main sequence
    ////////////////////
    initial
    begin
        void'($urandom(5469));
        for (int p = 0; p < video_pkg::PANE_CNT; p++)
            for (int i = 0; i < TAB_WORDS; i++)
                word_tab[p][i] = $urandom;
        repeat (16) @(posedge vout_clk);
        arst_n <= 1'b1;
        repeat (4) @(posedge vout_clk);
        for (int p = 0; p < video_pkg::PANE_CNT; p++)
            check_value("pane_rd after reset", 32'(pane_rd[p]), 32'd0);
        run_frame(-1);                          // digit still blank
        for (int d = 0; d <= 9; d++)
            run_frame(d);
        repeat (4) @(posedge vout_clk);         // last pixels through the pipe
        if (fail_cnt == 0)
        begin
            $display("TB PASSED");
            $finish;
        end
        else
        begin
            $display("TB FAILED");
            $fatal(1, "checks failed");
        end
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the last line was checked");
        $display("TB FAILED");
        $fatal(1, "timeout");
    end

endmodule

/* src.f */
logic/video_pkg.sv
logic/osd_pkg.sv
logic/pane_if.sv
logic/raster_counter.sv
logic/pane_fetch.sv
logic/pixel_unpack.sv
logic/osd_digit_reg.sv
logic/osd_overlay.sv
logic/vout_reader_top.sv
verification/vout_reader_checker.sv
verification/vout_reader_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator and run it; the exit status carries pass or fail
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module vout_reader_tb \
    -f src.f -Mdir obj_dir -o vout_reader_sim &&
./obj_dir/vout_reader_sim ||
{ echo "simulation failed"; exit 1; }
